/* common/coreLink.sv */
`timescale 1ns/10ps
`default_nettype none

interface coreLink import rvPkg::*; ();

   word_t   instr;
   logic    instrValid;    // one cycle, issue
   word_t   loadData;
   logic    loadDone;
   logic    memReq;
   logic    memWrite;
   word_t   memAddr;
   word_t   memWData;
   strobe_t memStrobe;
   logic    haltReq;

   modport fetch (
      output instr, instrValid, loadData, loadDone,
      input  memReq, memWrite, memAddr, memWData, memStrobe, haltReq
   );

   modport exec (
      input  instr, instrValid, loadData, loadDone,
      output memReq, memWrite, memAddr, memWData, memStrobe, haltReq
   );

endinterface

`default_nettype wire

/* common/regPort.sv */
`timescale 1ns/10ps
`default_nettype none

interface regPort import rvPkg::*; ();

   regAddr_t rAddr1;
   regAddr_t rAddr2;
   word_t    rData1;
   word_t    rData2;
   logic     wEn;
   regAddr_t wAddr;
   word_t    wData;

   modport regs (input rAddr1, rAddr2, wEn, wAddr, wData, output rData1, rData2);
   modport exec (output rAddr1, rAddr2, wEn, wAddr, wData, input rData1, rData2);

endinterface

`default_nettype wire

/* common/rvPkg.sv */
`default_nettype none

package rvPkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regAddr_t;
   typedef logic [3:0]  strobe_t;
   typedef logic [31:0] imm_t;    // already extended

   localparam logic [6:0] OPC_OPIMM = 7'b0010011;
   localparam logic [6:0] OPC_OP    = 7'b0110011;
   localparam logic [6:0] OPC_LUI   = 7'b0110111;
   localparam logic [6:0] OPC_LOAD  = 7'b0000011;
   localparam logic [6:0] OPC_STORE = 7'b0100011;
   localparam logic [6:0] OPC_HALT  = 7'h7F;

   typedef enum logic [3:0] {
      aluNone,
      aluAdd,
      aluSub,
      aluSll,
      aluSlt,
      aluSltu,
      aluXor,
      aluSrl,
      aluSra,
      aluOr,
      aluAnd,
      aluPass    // lui
   } aluOp_e;

   typedef enum logic [2:0] {
      ldB,
      ldBu,
      ldH,
      ldHu,
      ldW
   } loadKind_e;

   typedef enum logic [1:0] {
      stHalted,
      stFetch,
      stIssue,
      stDataAccess
   } fetchState_e;

endpackage

`default_nettype wire

/* core/execUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module execUnit import rvPkg::*; (
   input  logic   clk,
   input  logic   rstn,
   coreLink.exec  link,
   regPort.exec   rf
);

   aluOp_e    aluOp;
   regAddr_t  rd;
   regAddr_t  rs1;
   regAddr_t  rs2;
   imm_t      imm;
   logic      useImm;
   logic      isLoad;
   logic      isStore;
   logic      writesReg;
   logic      invalid;
   logic      isHalt;
   loadKind_e loadKind;
   strobe_t   storeStrobe;
   word_t     opB;
   word_t     aluResult;
   word_t     laneMask;
   word_t     loadExt;
   regAddr_t  pendRd;
   loadKind_e pendKind;

   opDecoder i_dec (
      .instr(link.instr), .aluOp(aluOp), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
      .useImm(useImm), .isLoad(isLoad), .isStore(isStore), .writesReg(writesReg),
      .invalid(invalid), .isHalt(isHalt), .loadKind(loadKind), .storeStrobe(storeStrobe)
   );

   intAlu i_alu (.aluOp(aluOp), .opA(rf.rData1), .opB(opB), .result(aluResult));

   assign rf.rAddr1 = rs1;
   assign rf.rAddr2 = rs2;
   assign opB       = useImm ? imm : rf.rData2;

   // byte lanes of the strobe, data is not shifted
   assign laneMask = {{8{storeStrobe[3]}}, {8{storeStrobe[2]}},
                      {8{storeStrobe[1]}}, {8{storeStrobe[0]}}};

   assign link.memReq    = link.instrValid && (isLoad || isStore) && !invalid;
   assign link.memWrite  = isStore;
   assign link.memAddr   = aluResult;
   assign link.memWData  = rf.rData2 & laneMask;
   assign link.memStrobe = storeStrobe;
   assign link.haltReq   = link.instrValid && (isHalt || invalid);

   always_comb begin
      case (pendKind)
         ldB:     loadExt = {{24{link.loadData[7]}}, link.loadData[7:0]};
         ldBu:    loadExt = {24'b0, link.loadData[7:0]};
         ldH:     loadExt = {{16{link.loadData[15]}}, link.loadData[15:0]};
         ldHu:    loadExt = {16'b0, link.loadData[15:0]};
         default: loadExt = link.loadData;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rf.wEn <= 1'b0;
      end else begin
         rf.wEn <= (link.instrValid && writesReg && !isLoad && !invalid) || link.loadDone;
      end
   end

   always_ff @(posedge clk) begin
      if (link.loadDone) begin
         rf.wAddr <= pendRd;
         rf.wData <= loadExt;
      end else begin
         rf.wAddr <= rd;
         rf.wData <= aluResult;
      end
      if (link.instrValid && isLoad) begin    // held until loadDone
         pendRd   <= rd;
         pendKind <= loadKind;
      end
   end

endmodule

`default_nettype wire

/* core/fetchUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchUnit import rvPkg::*; #(
   parameter word_t resetPc = '0
) (
   input  logic    clk,
   input  logic    rstn,
   input  logic    RVld,
   input  word_t   RData,
   input  logic    LEn,
   output logic    RRdy,
   output word_t   RAddr,
   output logic    RWEn,
   output word_t   RWData,
   output strobe_t RWStrobe,
   output logic    Halt,
   coreLink.fetch  link
);

   fetchState_e state;
   word_t       pc;
   word_t       instrReg;
   word_t       dataAddr;
   logic        dataWrite;    // pending access is a store

   // bus levels come straight from the state register
   assign Halt  = (state == stHalted);
   assign RRdy  = (state == stFetch) || (state == stDataAccess);
   assign RAddr = (state == stDataAccess) ? dataAddr : pc;
   assign RWEn  = (state == stDataAccess) && dataWrite;

   assign link.instr      = instrReg;
   assign link.instrValid = (state == stIssue);
   assign link.loadData   = RData;
   assign link.loadDone   = (state == stDataAccess) && RVld && !dataWrite;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= stHalted;
         pc        <= resetPc;
         dataWrite <= 1'b0;
      end else begin
         case (state)
            stHalted: begin
               if (LEn) begin
                  state <= stFetch;
               end
            end
            stFetch: begin
               if (RVld) begin
                  state <= stIssue;
               end
            end
            stIssue: begin
               if (link.haltReq) begin
                  state <= stHalted;
                  pc    <= pc + 32'd1;    // resume at next word
               end else if (link.memReq) begin
                  state     <= stDataAccess;
                  dataWrite <= link.memWrite;
               end else begin
                  state <= stFetch;
                  pc    <= pc + 32'd1;
               end
            end
            stDataAccess: begin
               if (RVld) begin
                  state     <= stFetch;
                  pc        <= pc + 32'd1;
                  dataWrite <= 1'b0;
               end
            end
            default: state <= stHalted;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == stFetch && RVld) begin
         instrReg <= RData;
      end
      // held until RVld ends the data access
      if (state == stIssue && link.memReq) begin
         dataAddr <= link.memAddr;
         RWData   <= link.memWData;
         RWStrobe <= link.memStrobe;
      end
   end

endmodule

`default_nettype wire

/* core/intAlu.sv */
`timescale 1ns/10ps
`default_nettype none

module intAlu import rvPkg::*; (
   input  aluOp_e aluOp,
   input  word_t  opA,
   input  word_t  opB,
   output word_t  result
);

   logic [4:0] shamt;

   assign shamt = opB[4:0];

   always_comb begin
      case (aluOp)
         aluAdd:  result = opA + opB;    // also load/store address
         aluSub:  result = opA - opB;
         aluSll:  result = opA << shamt;
         aluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
         aluSltu: result = {31'b0, opA < opB};
         aluXor:  result = opA ^ opB;
         aluSrl:  result = opA >> shamt;
         aluSra:  result = word_t'($signed(opA) >>> shamt);
         aluOr:   result = opA | opB;
         aluAnd:  result = opA & opB;
         aluPass: result = opB;
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

/* core/opDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module opDecoder import rvPkg::*; (
   input  word_t     instr,
   output aluOp_e    aluOp,
   output regAddr_t  rd,
   output regAddr_t  rs1,
   output regAddr_t  rs2,
   output imm_t      imm,
   output logic      useImm,
   output logic      isLoad,
   output logic      isStore,
   output logic      writesReg,
   output logic      invalid,
   output logic      isHalt,
   output loadKind_e loadKind,
   output strobe_t   storeStrobe
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign rd  = instr[11:7];
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];

   always_comb begin
      aluOp       = aluNone;
      imm         = '0;
      useImm      = 1'b0;
      isLoad      = 1'b0;
      isStore     = 1'b0;
      writesReg   = 1'b0;
      invalid     = 1'b0;
      isHalt      = 1'b0;
      loadKind    = ldW;
      storeStrobe = '0;
      case (opcode)
         OPC_OPIMM, OPC_OP: begin
            useImm    = (opcode == OPC_OPIMM);
            writesReg = 1'b1;
            imm       = {{20{instr[31]}}, instr[31:20]};
            case (funct3)
               3'b000: aluOp = (opcode == OPC_OP && funct7[5]) ? aluSub : aluAdd;
               3'b001: aluOp = aluSll;
               3'b010: aluOp = aluSlt;
               3'b011: aluOp = aluSltu;
               3'b100: aluOp = aluXor;
               3'b101: aluOp = funct7[5] ? aluSra : aluSrl;
               3'b110: aluOp = aluOr;
               default: aluOp = aluAnd;
            endcase
            // immediates only check funct7 on shifts
            if (opcode == OPC_OP || funct3 == 3'b001 || funct3 == 3'b101) begin
               if (funct7 == 7'b0100000) begin
                  invalid = !(funct3 == 3'b101 || (funct3 == 3'b000 && opcode == OPC_OP));
               end else if (funct7 != 7'b0000000) begin
                  invalid = 1'b1;
               end
            end
         end
         OPC_LUI: begin
            aluOp     = aluPass;
            useImm    = 1'b1;
            writesReg = 1'b1;
            imm       = {instr[31:12], 12'h000};
         end
         OPC_LOAD: begin
            aluOp     = aluAdd;
            useImm    = 1'b1;
            isLoad    = 1'b1;
            writesReg = 1'b1;
            imm       = {{20{instr[31]}}, instr[31:20]};
            case (funct3)
               3'b000: loadKind = ldB;
               3'b001: loadKind = ldH;
               3'b010: loadKind = ldW;
               3'b100: loadKind = ldBu;
               3'b101: loadKind = ldHu;
               default: invalid = 1'b1;
            endcase
         end
         OPC_STORE: begin
            aluOp   = aluAdd;
            useImm  = 1'b1;
            isStore = 1'b1;
            imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            case (funct3)
               3'b000: storeStrobe = 4'b0001;    // low lanes only
               3'b001: storeStrobe = 4'b0011;
               3'b010: storeStrobe = 4'b1111;
               default: invalid = 1'b1;
            endcase
         end
         OPC_HALT: isHalt = 1'b1;
         default: invalid = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

/* core/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile import rvPkg::*; (
   input  logic  clk,
   input  logic  rstn,
   regPort.regs  rf
);

   word_t regs [32];

   // x0 reads as zero
   assign rf.rData1 = (rf.rAddr1 == '0) ? '0 : regs[rf.rAddr1];
   assign rf.rData2 = (rf.rAddr2 == '0) ? '0 : regs[rf.rAddr2];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (rf.wEn && rf.wAddr != '0) begin
         regs[rf.wAddr] <= rf.wData;
      end
   end

endmodule

`default_nettype wire

/* filelist.f */
common/rvPkg.sv
common/coreLink.sv
common/regPort.sv
core/fetchUnit.sv
core/opDecoder.sv
core/intAlu.sv
core/execUnit.sv
core/regFile.sv
src/rvCoreTop.sv
tests/tbClock.sv
tests/coreTb_assert.sv
tests/coreTb.sv

/* src/rvCoreTop.sv */
`timescale 1ns/10ps
`default_nettype none

module rvCoreTop import rvPkg::*; #(
   parameter word_t resetPc = '0
) (
   input  logic    clk,
   input  logic    rstn,
   input  logic    RVld,
   input  word_t   RData,
   input  logic    LEn,
   output logic    RRdy,
   output word_t   RAddr,
   output logic    RWEn,
   output word_t   RWData,
   output strobe_t RWStrobe,
   output logic    Halt
);

   coreLink link ();
   regPort  rp ();

   fetchUnit #(.resetPc(resetPc)) i_fetch (
      .clk(clk),
      .rstn(rstn),
      .RVld(RVld),
      .RData(RData),
      .LEn(LEn),
      .RRdy(RRdy),
      .RAddr(RAddr),
      .RWEn(RWEn),
      .RWData(RWData),
      .RWStrobe(RWStrobe),
      .Halt(Halt),
      .link(link.fetch)
   );

   execUnit i_exec (.clk(clk), .rstn(rstn), .link(link.exec), .rf(rp.exec));

   regFile i_regs (.clk(clk), .rstn(rstn), .rf(rp.regs));

endmodule

`default_nettype wire

/* tests/coreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module coreTb import rvPkg::*; ();

   localparam int    maxCycles = 4000;    // about 80 instructions at worst waits plus margin
   localparam word_t startPc   = 32'd0;
   localparam word_t haltWord  = 32'h0000_007F;
   localparam word_t storeVal  = 32'h89AB_CDEF;

   logic    clk;
   logic    rstn;
   logic    RVld = 1'b0;
   word_t   RData = '0;
   logic    LEn = 1'b0;
   logic    RRdy;
   word_t   RAddr;
   logic    RWEn;
   word_t   RWData;
   strobe_t RWStrobe;
   logic    Halt;

   word_t mem [256];
   word_t lfsrState = 32'h1760_1812;
   logic  busy = 1'b0;
   int    waitLeft = 0;
   int    cycleCount = 0;
   int    loadPtr = 0;
   int    slotPtr = 160;    // result words from here on
   int    testCount = 0;
   int    errorCount = 0;
   int    expAddr [$];
   word_t expVal [$];

   tbClock i_clock (.clk(clk), .rstn(rstn));

   rvCoreTop #(.resetPc(startPc)) i_dut (
      .clk(clk), .rstn(rstn), .RVld(RVld), .RData(RData), .LEn(LEn),
      .RRdy(RRdy), .RAddr(RAddr), .RWEn(RWEn), .RWData(RWData),
      .RWStrobe(RWStrobe), .Halt(Halt)
   );

   function automatic word_t lfsrNext(input word_t s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic word_t fillWord(input int i);
      return {8'hA5, 8'(i), 8'(~i), 8'(i ^ 8'h3C)};
   endfunction

   function automatic word_t rType(input logic [6:0] f7, input regAddr_t rs2, rs1,
                                   input logic [2:0] f3, input regAddr_t rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic word_t iType(input logic [11:0] imm, input regAddr_t rs1,
                                   input logic [2:0] f3, input regAddr_t rd,
                                   input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t sType(input logic [11:0] imm, input regAddr_t rs2, rs1,
                                   input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
   endfunction

   function automatic word_t uType(input logic [19:0] upper, input regAddr_t rd);
      return {upper, rd, OPC_LUI};
   endfunction

   task automatic nextWait(output int w);
      w = 0;
      for (int i = 0; i < 2; i++) begin
         w = (w << 1) | lfsrState[0];
         lfsrState = lfsrNext(lfsrState);
      end
   endtask

   task automatic putWord(input word_t w);
      mem[loadPtr] = w;
      loadPtr++;
   endtask

   task automatic expectSlot(input word_t v);
      expAddr.push_back(slotPtr);
      expVal.push_back(v);
      slotPtr++;
   endtask

   // instruction writes x3 and SW x3 stores it in the next slot
   task automatic opResult(input word_t instr, input word_t expected);
      putWord(instr);
      putWord(sType(12'(slotPtr), 3, 0, 3'b010));
      expectSlot(expected);
   endtask

   // x4 holds storeVal and untouched lanes keep the fill
   task automatic storeLane(input logic [2:0] f3, input word_t laneMask);
      putWord(sType(12'(slotPtr), 4, 0, f3));
      expectSlot((mem[slotPtr] & ~laneMask) | (storeVal & laneMask));
   endtask

   task automatic runFrom(input string name, input int startAddr, inout int bad);
      @(negedge clk);
      LEn = 1'b1;
      @(negedge clk);
      LEn = 1'b0;
      if (RAddr !== word_t'(startAddr)) begin
         $display("FAIL %s: first fetch expected %h, actual %h", name, word_t'(startAddr), RAddr);
         bad++;
      end
      while (Halt !== 1'b1) begin
         @(negedge clk);
      end
   endtask

   task automatic compareResults(input string name, inout int bad);
      int    addr;
      word_t want;
      while (expAddr.size() > 0) begin
         addr = expAddr.pop_front();
         want = expVal.pop_front();
         if (mem[addr] !== want) begin
            $display("FAIL %s: word %0d expected %h, actual %h", name, addr, want, mem[addr]);
            bad++;
         end
      end
   endtask

   task automatic finishTest(input string name, input int bad);
      testCount++;
      errorCount += bad;
      if (bad == 0) begin
         $display("%s: pass", name);
      end else begin
         $display("%s: %0d errors", name, bad);
      end
   endtask

   // memory answers after 0 to 3 wait cycles
   always @(negedge clk) begin
      if (!rstn || RVld) begin
         RVld = 1'b0;    // transfer closed at the last rising edge
         busy = 1'b0;
      end else if (RRdy) begin
         if (!busy) begin
            busy = 1'b1;
            nextWait(waitLeft);
         end
         if (waitLeft == 0) begin
            RData = mem[RAddr[7:0]];
            for (int b = 0; b < 4; b++) begin
               if (RWEn && RWStrobe[b]) begin
                  mem[RAddr[7:0]][8*b +: 8] = RWData[8*b +: 8];
               end
            end
            RVld = 1'b1;
         end else begin
            waitLeft--;
         end
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= maxCycles) begin
         $display("timeout: core did not halt within %0d cycles", maxCycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   initial begin
      word_t a;
      word_t b;
      word_t d;
      int    progStart;
      int    resumeAt;
      int    bad;
      int    assertFails;
      for (int i = 0; i < 256; i++) begin
         mem[i] = fillWord(i);
      end
      a = 32'h8765_4321;
      b = 32'h0001_1FFB;
      d = 32'hF0E1_8293;
      mem[240] = d;
      loadPtr = startPc;
      @(posedge rstn);

      bad = 0;
      repeat (3) begin
         @(negedge clk);
         if (!(Halt === 1'b1 && RRdy === 1'b0 && RWEn === 1'b0)) begin
            $display("FAIL reset: Halt/RRdy/RWEn expected 100, actual %b%b%b", Halt, RRdy, RWEn);
            bad++;
         end
      end
      finishTest("reset", bad);

      bad = 0;
      progStart = loadPtr;
      putWord(uType(20'h87654, 1));
      putWord(iType(12'h321, 1, 3'b000, 1, OPC_OPIMM));
      putWord(uType(20'h00012, 2));
      putWord(iType(12'hFFB, 2, 3'b000, 2, OPC_OPIMM));
      opResult(iType(12'hF9C, 1, 3'b000, 3, OPC_OPIMM), a + 32'hFFFF_FF9C);
      opResult(iType(12'd5, 1, 3'b010, 3, OPC_OPIMM), ($signed(a) < 5) ? 32'd1 : 32'd0);
      opResult(iType(12'd5, 1, 3'b011, 3, OPC_OPIMM), (a < 32'd5) ? 32'd1 : 32'd0);
      opResult(iType(12'hFFF, 1, 3'b100, 3, OPC_OPIMM), ~a);
      opResult(iType(12'h0F0, 1, 3'b110, 3, OPC_OPIMM), a | 32'h0F0);
      opResult(iType(12'h7FF, 1, 3'b111, 3, OPC_OPIMM), a & 32'h7FF);
      opResult(iType(12'h004, 1, 3'b001, 3, OPC_OPIMM), a << 4);
      opResult(iType(12'h008, 1, 3'b101, 3, OPC_OPIMM), a >> 8);
      opResult(iType(12'h408, 1, 3'b101, 3, OPC_OPIMM), {{8{a[31]}}, a[31:8]});
      opResult(rType(7'h00, 2, 1, 3'b000, 3), a + b);
      opResult(rType(7'h20, 2, 1, 3'b000, 3), a - b);
      opResult(rType(7'h00, 2, 1, 3'b001, 3), a << b[4:0]);
      opResult(rType(7'h00, 2, 1, 3'b010, 3), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
      opResult(rType(7'h00, 2, 1, 3'b011, 3), (a < b) ? 32'd1 : 32'd0);
      opResult(rType(7'h00, 2, 1, 3'b100, 3), a ^ b);
      opResult(rType(7'h00, 2, 1, 3'b101, 3), a >> b[4:0]);
      opResult(rType(7'h20, 2, 1, 3'b101, 3), {{27{a[31]}}, a[31:27]});    // shamt 27
      opResult(rType(7'h00, 2, 1, 3'b110, 3), a | b);
      opResult(rType(7'h00, 2, 1, 3'b111, 3), a & b);
      opResult(uType(20'hABCDE, 3), 32'hABCD_E000);
      putWord(iType(12'd55, 0, 3'b000, 0, OPC_OPIMM));    // x0 stays zero
      putWord(sType(12'(slotPtr), 0, 0, 3'b010));
      expectSlot('0);
      putWord(haltWord);
      runFrom("alu", progStart, bad);
      compareResults("alu", bad);
      finishTest("alu", bad);

      bad = 0;
      progStart = loadPtr;
      putWord(iType(12'd200, 0, 3'b000, 6, OPC_OPIMM));    // base 200 plus offset 40
      opResult(iType(12'd40, 6, 3'b000, 3, OPC_LOAD), {{24{d[7]}}, d[7:0]});
      opResult(iType(12'd40, 6, 3'b100, 3, OPC_LOAD), {24'b0, d[7:0]});
      opResult(iType(12'd40, 6, 3'b001, 3, OPC_LOAD), {{16{d[15]}}, d[15:0]});
      opResult(iType(12'd40, 6, 3'b101, 3, OPC_LOAD), {16'b0, d[15:0]});
      opResult(iType(12'd40, 6, 3'b010, 3, OPC_LOAD), d);
      putWord(haltWord);
      runFrom("load", progStart, bad);
      compareResults("load", bad);
      finishTest("load", bad);

      bad = 0;
      progStart = loadPtr;
      putWord(uType(20'h89ABD, 4));
      putWord(iType(12'hDEF, 4, 3'b000, 4, OPC_OPIMM));
      storeLane(3'b000, 32'h0000_00FF);
      storeLane(3'b001, 32'h0000_FFFF);
      storeLane(3'b010, 32'hFFFF_FFFF);
      putWord(haltWord);
      runFrom("store", progStart, bad);
      compareResults("store", bad);
      finishTest("store", bad);

      bad = 0;
      progStart = loadPtr;
      putWord(iType(12'd77, 0, 3'b000, 3, OPC_OPIMM));
      putWord(iType({7'b0000001, 5'd4}, 1, 3'b101, 5, OPC_OPIMM));    // SRLI with bad funct7
      resumeAt = loadPtr;
      putWord(sType(12'(slotPtr), 3, 0, 3'b010));
      expectSlot(32'd77);
      putWord(sType(12'(slotPtr), 5, 0, 3'b010));    // x5 never written
      expectSlot('0);
      putWord(haltWord);
      runFrom("halt", progStart, bad);
      repeat (8) begin
         @(negedge clk);
         if (RRdy !== 1'b0 || Halt !== 1'b1) begin
            $display("halt: core left the halted state without LEn");
            bad++;
         end
      end
      runFrom("halt", resumeAt, bad);
      compareResults("halt", bad);
      finishTest("halt", bad);

      assertFails = i_dut.i_assert.failCount;
      errorCount += assertFails;
      $display("%0d tests, %0d errors, %0d assertion failures",
               testCount, errorCount, assertFails);
      if (errorCount == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tests/coreTb_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module coreAssert import rvPkg::*; (
   input logic    clk,
   input logic    rstn,
   input logic    RVld,
   input logic    LEn,
   input logic    RRdy,
   input logic    RWEn,
   input logic    Halt,
   input word_t   RAddr,
   input word_t   RWData,
   input strobe_t RWStrobe
);

   int failCount = 0;

   resetHalts: assert property (@(posedge clk) !rstn |=> Halt && !RRdy && !RWEn)
      else begin
         $error("core not halted and idle after reset");
         failCount++;
      end

   // request held until the memory answers
   requestHeld: assert property (@(posedge clk) disable iff (!rstn)
      RRdy && !RVld |=> RRdy && $stable(RAddr) && $stable(RWEn))
      else begin
         $error("RRdy or RAddr changed while waiting for RVld");
         failCount++;
      end

   storeHeld: assert property (@(posedge clk) disable iff (!rstn)
      RRdy && RWEn && !RVld |=> $stable(RWData) && $stable(RWStrobe))
      else begin
         $error("store data or strobe changed while waiting for RVld");
         failCount++;
      end

   haltHeld: assert property (@(posedge clk) disable iff (!rstn) Halt && !LEn |=> Halt)
      else begin
         $error("core left halt without LEn");
         failCount++;
      end

   startFetch: assert property (@(posedge clk) disable iff (!rstn) $fell(Halt) |-> RRdy && !RWEn)
      else begin
         $error("no fetch after leaving halt");
         failCount++;
      end

   storeLanes: assert property (@(posedge clk) disable iff (!rstn)
      RRdy && RWEn |-> (RWStrobe == 4'b0001 && RWData[31:8] == '0)
                    || (RWStrobe == 4'b0011 && RWData[31:16] == '0)
                    || RWStrobe == 4'b1111)
      else begin
         $error("store strobe or masked data wrong");
         failCount++;
      end

endmodule

bind rvCoreTop coreAssert i_assert (.*);

`default_nettype wire

/* tests/tbClock.sv */
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
   parameter int halfPeriod  = 4,
   parameter int resetCycles = 2
) (
   output logic clk,
   output logic rstn
);

   initial begin
      clk  = 1'b0;
      rstn = 1'b0;
      fork
         forever #(halfPeriod) clk = ~clk;
         begin
            repeat (resetCycles) @(posedge clk);
            @(negedge clk) rstn = 1'b1;    // released on a falling edge
         end
      join_none
   end

endmodule

`default_nettype wire
